// File: nvme_host_top.f
+incdir+.
nvme_pkg.sv
ring_index.sv
sq_submit.sv
sq_doorbell.sv
cq_poller.sv
write_response.sv
nvme_host_top.sv
nvme_host_tb.sv

// File: Bender.yml
package:
  name: nvme_host

sources:
  - include_dirs:
      - .
    files:
      - nvme_pkg.sv
      - ring_index.sv
      - sq_submit.sv
      - sq_doorbell.sv
      - cq_poller.sv
      - write_response.sv
      - nvme_host_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - nvme_host_tb.sv

// File: nvme_host_tb.sv
`timescale 1ns/10ps

`include "nvme_params.svh"

module nvme_host_tb;

  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  // 43 commands over all tests plus resets, stalls and settle time
  localparam int NUM_CMDS    = 43;
  localparam int CMD_CYCLES  = 16;
  localparam int CYCLE_LIMIT = NUM_CMDS * CMD_CYCLES + 400;

  logic                clk;
  logic                rstn;
  logic                req_valid;
  logic [47:0]         req_addr;
  logic                req_ready;
  logic                sq_wvalid;
  logic [31:0]         sq_waddr;
  nvme_pkg::sqe_t      sq_wdata;
  logic                sq_wready;
  logic                sqdb_valid;
  logic [31:0]         sqdb_addr;
  logic [31:0]         sqdb_data;
  logic                sqdb_ready;
  logic                cq_arvalid;
  logic [31:0]         cq_araddr;
  logic                cq_arready;
  logic                cq_rvalid;
  nvme_pkg::cqe_t      cq_rdata;
  logic                cq_rready;
  logic                cqdb_valid;
  logic [31:0]         cqdb_addr;
  logic [31:0]         cqdb_data;
  logic                cqdb_ready;
  logic                resp_valid;
  logic                resp_ready;

  // transfers seen on the memory side
  logic [31:0]         sqw_addr_q[$];
  nvme_pkg::sqe_t      sqw_data_q[$];
  logic [31:0]         sqdb_addr_q[$];
  logic [31:0]         sqdb_data_q[$];
  logic [31:0]         ar_q[$];
  logic [31:0]         cqdb_addr_q[$];
  logic [31:0]         cqdb_data_q[$];
  int                  r_count;
  int                  resp_count;

  // CQ memory model written by the tests as the controller would
  nvme_pkg::cqe_t      cq_mem[16];
  int                  cq_tail;
  logic                cq_phase;
  nvme_pkg::cqe_t      rd_entry;
  logic                rd_due = 1'b0;
  logic                r_done = 1'b0;

  logic [31:0]         lfsr;
  int                  cycle_count = 0;
  int                  errors;
  int                  tests_run;
  int                  tests_failed;

  nvme_host_top nvme_host_top_inst (
    .clk        (clk),
    .rstn       (rstn),
    .req_valid  (req_valid),
    .req_addr   (req_addr),
    .req_ready  (req_ready),
    .sq_wvalid  (sq_wvalid),
    .sq_waddr   (sq_waddr),
    .sq_wdata   (sq_wdata),
    .sq_wready  (sq_wready),
    .sqdb_valid (sqdb_valid),
    .sqdb_addr  (sqdb_addr),
    .sqdb_data  (sqdb_data),
    .sqdb_ready (sqdb_ready),
    .cq_arvalid (cq_arvalid),
    .cq_araddr  (cq_araddr),
    .cq_arready (cq_arready),
    .cq_rvalid  (cq_rvalid),
    .cq_rdata   (cq_rdata),
    .cq_rready  (cq_rready),
    .cqdb_valid (cqdb_valid),
    .cqdb_addr  (cqdb_addr),
    .cqdb_data  (cqdb_data),
    .cqdb_ready (cqdb_ready),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
  );

  always #2 clk = ~clk;

  // sampled mid-cycle so each hit is a transfer on the next rising edge
  always @(negedge clk) begin
    if (sq_wvalid && sq_wready) begin
      sqw_addr_q.push_back(sq_waddr);
      sqw_data_q.push_back(sq_wdata);
    end
    if (sqdb_valid && sqdb_ready) begin
      sqdb_addr_q.push_back(sqdb_addr);
      sqdb_data_q.push_back(sqdb_data);
    end
    if (cq_arvalid && cq_arready) begin
      ar_q.push_back(cq_araddr);
      rd_entry = cq_mem[cq_araddr[7:4]];
      rd_due   = 1'b1;
    end
    if (cq_rvalid && cq_rready) begin
      r_done = 1'b1;
      r_count++;
    end
    if (cqdb_valid && cqdb_ready) begin
      cqdb_addr_q.push_back(cqdb_addr);
      cqdb_data_q.push_back(cqdb_data);
    end
    if (resp_valid && resp_ready) begin
      resp_count++;
    end
  end

  // run limit, and read data one cycle after the address
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
    end else begin
      #1;
      if (r_done) begin
        cq_rvalid = 1'b0;
        r_done    = 1'b0;
      end
      if (rd_due) begin
        cq_rvalid = 1'b1;
        cq_rdata  = rd_entry;
        rd_due    = 1'b0;
      end
    end
  end

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v    = {v[62:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) tick();
  endtask

  task automatic report_mismatch(input string name, input logic [255:0] got,
                                 input logic [255:0] exp);
    $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
    errors++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic apply_reset();
    int s;
    rstn      = 1'b0;
    req_valid = 1'b0;
    cq_rvalid = 1'b0;
    rd_due    = 1'b0;
    r_done    = 1'b0;
    sqw_addr_q.delete();
    sqw_data_q.delete();
    sqdb_addr_q.delete();
    sqdb_data_q.delete();
    ar_q.delete();
    cqdb_addr_q.delete();
    cqdb_data_q.delete();
    r_count    = 0;
    resp_count = 0;
    cq_tail    = 0;
    // first lap entries carry phase 1 so the zero fill reads as stale
    cq_phase   = 1'b1;
    for (s = 0; s < 16; s++) begin
      cq_mem[s]     = '0;
      cq_mem[s].dw0 = 32'(s * `NVME_CQE_BYTES);
    end
    wait_cycles(5);
    rstn = 1'b1;
    tick();
  endtask

  task automatic post_cqe(input int cid, input int head);
    nvme_pkg::cqe_t e;
    e         = '0;
    e.sq_head = 16'(head);
    e.sq_id   = 16'd1;
    e.cid     = 16'(cid);
    e.phase   = cq_phase;
    cq_mem[cq_tail] = e;
    if (cq_tail == 15) begin
      cq_tail  = 0;
      cq_phase = ~cq_phase;
    end else begin
      cq_tail++;
    end
  endtask

  task automatic send_req(input logic [47:0] addr);
    int n;
    n         = sqw_addr_q.size();
    req_valid = 1'b1;
    req_addr  = addr;
    while (sqw_addr_q.size() == n) tick();
    req_valid = 1'b0;
  endtask

  task automatic wait_cqdb(input int n);
    while (cqdb_data_q.size() < n) tick();
  endtask

  task automatic wait_resp(input int n);
    while (resp_count < n) tick();
  endtask

  task automatic check_sqe(input int i, input int cid, input logic [47:0] addr);
    nvme_pkg::sqe_t e;
    logic [127:0]   exp_dptr;
    logic [255:0]   reserved;
    e        = sqw_data_q[i];
    // 516 MiB base plus one 4 KiB slot per cid
    exp_dptr = {96'h0, 32'h2040_0000 + 32'(cid) * 32'd4096};
    reserved = {e.cdw2_3, e.mptr, e.cdw12, e.cdw13, e.cdw14, e.cdw15};
    if (sqw_addr_q[i] !== 32'(cid * `NVME_SQE_BYTES))
      report_mismatch("sq_waddr", sqw_addr_q[i], cid * `NVME_SQE_BYTES);
    if (e.cdw0 !== {16'(cid), 8'h00, `NVME_OPC_WRITE})
      report_mismatch("sqe cdw0", e.cdw0, {16'(cid), 8'h00, `NVME_OPC_WRITE});
    if (e.nsid !== 32'd1)
      report_mismatch("sqe nsid", e.nsid, 1);
    if (e.dptr !== exp_dptr)
      report_mismatch("sqe dptr", e.dptr, exp_dptr);
    if (e.slba !== {28'h0, addr[47:12]})
      report_mismatch("sqe slba", e.slba, {28'h0, addr[47:12]});
    if (reserved !== '0)
      report_mismatch("sqe reserved", reserved, 0);
  endtask

  task automatic single_write();
    int          e0;
    logic [47:0] addr;
    e0   = errors;
    addr = 48'(rand_bits(48));
    apply_reset();
    send_req(addr);
    post_cqe(0, 1);
    wait_cqdb(1);
    wait_resp(1);
    wait_cycles(4);
    check_sqe(0, 0, addr);
    if (sqdb_addr_q[0] !== `NVME_SQ1TDBL)
      report_mismatch("sqdb_addr", sqdb_addr_q[0], `NVME_SQ1TDBL);
    if (sqdb_data_q[0] !== 32'd1)
      report_mismatch("sqdb_data", sqdb_data_q[0], 1);
    if (ar_q[0] !== 32'd0)
      report_mismatch("cq_araddr", ar_q[0], 0);
    if (cqdb_addr_q[0] !== `NVME_CQ1HDBL)
      report_mismatch("cqdb_addr", cqdb_addr_q[0], `NVME_CQ1HDBL);
    if (cqdb_data_q[0] !== 32'd1)
      report_mismatch("cqdb_data", cqdb_data_q[0], 1);
    if (resp_count != 1)
      report_mismatch("resp count", resp_count, 1);
    finish_test("single_write", e0);
  endtask

  task automatic poll_retry();
    int e0;
    int n;
    int k;
    e0 = errors;
    n  = 2 + int'(rand_bits(3));
    apply_reset();
    send_req(48'(rand_bits(48)));
    // slot 0 still holds the stale fill
    while (r_count < n) tick();
    if (resp_count != 0)
      report_mismatch("resp count while stale", resp_count, 0);
    post_cqe(0, 1);
    wait_cqdb(1);
    wait_resp(1);
    wait_cycles(4);
    for (k = 0; k < ar_q.size(); k++) begin
      if (ar_q[k] !== 32'd0)
        report_mismatch("cq_araddr on retry", ar_q[k], 0);
    end
    if (cqdb_data_q[0] !== 32'd1)
      report_mismatch("cqdb_data", cqdb_data_q[0], 1);
    if (resp_count != 1)
      report_mismatch("resp count", resp_count, 1);
    finish_test("poll_retry", e0);
  endtask

  task automatic back_to_back();
    int          e0;
    int          k;
    logic [47:0] addrs[3];
    e0 = errors;
    apply_reset();
    for (k = 0; k < 3; k++) begin
      addrs[k] = 48'(rand_bits(48));
      send_req(addrs[k]);
    end
    while (sqdb_data_q.size() < 3) tick();
    wait_cycles(4);
    for (k = 0; k < 3; k++) begin
      check_sqe(k, k, addrs[k]);
      if (sqdb_data_q[k] !== 32'(k + 1))
        report_mismatch("sqdb_data", sqdb_data_q[k], k + 1);
    end
    if (resp_count != 0)
      report_mismatch("resp count", resp_count, 0);
    finish_test("back_to_back", e0);
  endtask

  task automatic out_of_order();
    int e0;
    e0 = errors;
    apply_reset();
    send_req(48'(rand_bits(48)));
    send_req(48'(rand_bits(48)));
    post_cqe(1, 2);
    wait_cqdb(1);
    wait_cycles(6);
    // cid 0 still outstanding so nothing may be answered
    if (resp_count != 0)
      report_mismatch("resp count after cid 1", resp_count, 0);
    post_cqe(0, 2);
    wait_cqdb(2);
    wait_resp(2);
    wait_cycles(4);
    if (cqdb_data_q[1] !== 32'd2)
      report_mismatch("cqdb_data", cqdb_data_q[1], 2);
    if (resp_count != 2)
      report_mismatch("resp count after cid 0", resp_count, 2);
    finish_test("out_of_order", e0);
  endtask

  task automatic queue_full();
    int          e0;
    int          k;
    int          stall;
    logic [47:0] addr;
    e0    = errors;
    stall = 6 + int'(rand_bits(4));
    apply_reset();
    for (k = 0; k < 15; k++) begin
      send_req(48'(rand_bits(48)));
    end
    addr      = 48'(rand_bits(48));
    req_valid = 1'b1;
    req_addr  = addr;
    repeat (stall) begin
      @(negedge clk);
      if (req_ready !== 1'b0)
        report_mismatch("req_ready with SQ full", req_ready, 0);
      tick();
    end
    if (sqw_addr_q.size() != 15)
      report_mismatch("accepted count", sqw_addr_q.size(), 15);
    post_cqe(0, 1);
    send_req(addr);
    wait_resp(1);
    wait_cycles(2);
    check_sqe(15, 15, addr);
    finish_test("queue_full", e0);
  endtask

  task automatic wrap();
    int e0;
    int i;
    int rb;
    e0 = errors;
    apply_reset();
    for (i = 0; i < 20; i++) begin
      rb = r_count;
      send_req(48'(rand_bits(48)));
      if (i >= 16) begin
        // old lap entry must read as stale before the new one lands
        while (r_count == rb) tick();
        wait_cycles(2);
        if (cqdb_data_q.size() != i)
          report_mismatch("cqdb count on stale lap", cqdb_data_q.size(), i);
        if (resp_count != i)
          report_mismatch("resp count on stale lap", resp_count, i);
      end
      post_cqe(i % 16, (i + 1) % 16);
      wait_cqdb(i + 1);
      if (ar_q[$] !== 32'((i % 16) * `NVME_CQE_BYTES))
        report_mismatch("cq_araddr", ar_q[$], (i % 16) * `NVME_CQE_BYTES);
      if (sqw_addr_q[i] !== 32'((i % 16) * `NVME_SQE_BYTES))
        report_mismatch("sq_waddr", sqw_addr_q[i], (i % 16) * `NVME_SQE_BYTES);
      if (sqdb_data_q[i] !== 32'((i + 1) % 16))
        report_mismatch("sqdb_data", sqdb_data_q[i], (i + 1) % 16);
      if (cqdb_data_q[i] !== 32'((i + 1) % 16))
        report_mismatch("cqdb_data", cqdb_data_q[i], (i + 1) % 16);
    end
    wait_resp(20);
    wait_cycles(4);
    if (resp_count != 20)
      report_mismatch("resp count", resp_count, 20);
    finish_test("wrap", e0);
  endtask

  initial begin
    clk          = 1'b0;
    rstn         = 1'b0;
    req_valid    = 1'b0;
    req_addr     = '0;
    sq_wready    = 1'b1;
    sqdb_ready   = 1'b1;
    cq_arready   = 1'b1;
    cq_rvalid    = 1'b0;
    cq_rdata     = '0;
    cqdb_ready   = 1'b1;
    resp_ready   = 1'b1;
    lfsr         = 32'h19ecaf2a;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    single_write();
    poll_retry();
    back_to_back();
    out_of_order();
    queue_full();
    wrap();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: nvme_host_top.sv
`timescale 1ns/10ps

`include "nvme_params.svh"

module nvme_host_top (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         req_valid,
  input  logic [`NVME_HOST_ADDR_W-1:0] req_addr,
  output logic                         req_ready,
  output logic                         sq_wvalid,
  output logic [`NVME_MEM_ADDR_W-1:0]  sq_waddr,
  output nvme_pkg::sqe_t               sq_wdata,
  input  logic                         sq_wready,
  output logic                         sqdb_valid,
  output logic [`NVME_MEM_ADDR_W-1:0]  sqdb_addr,
  output logic [`NVME_DB_W-1:0]        sqdb_data,
  input  logic                         sqdb_ready,
  output logic                         cq_arvalid,
  output logic [`NVME_MEM_ADDR_W-1:0]  cq_araddr,
  input  logic                         cq_arready,
  input  logic                         cq_rvalid,
  input  nvme_pkg::cqe_t               cq_rdata,
  output logic                         cq_rready,
  output logic                         cqdb_valid,
  output logic [`NVME_MEM_ADDR_W-1:0]  cqdb_addr,
  output logic [`NVME_DB_W-1:0]        cqdb_data,
  input  logic                         cqdb_ready,
  output logic                         resp_valid,
  input  logic                         resp_ready
);

  nvme_pkg::qidx_t    sq_head;
  nvme_pkg::cid_vec_t cid_state;
  logic               sqe_written;
  logic               db_rung;

  sq_submit sq_submit_inst (
    .clk         (clk),
    .rstn        (rstn),
    .req_valid   (req_valid),
    .req_addr    (req_addr),
    .req_ready   (req_ready),
    .sq_head     (sq_head),
    .cid_state   (cid_state),
    .sq_wvalid   (sq_wvalid),
    .sq_waddr    (sq_waddr),
    .sq_wdata    (sq_wdata),
    .sq_wready   (sq_wready),
    .sqe_written (sqe_written)
  );

  sq_doorbell sq_doorbell_inst (
    .clk         (clk),
    .rstn        (rstn),
    .sqe_written (sqe_written),
    .sqdb_valid  (sqdb_valid),
    .sqdb_addr   (sqdb_addr),
    .sqdb_data   (sqdb_data),
    .sqdb_ready  (sqdb_ready),
    .db_rung     (db_rung)
  );

  cq_poller cq_poller_inst (
    .clk        (clk),
    .rstn       (rstn),
    .db_rung    (db_rung),
    .cq_arvalid (cq_arvalid),
    .cq_araddr  (cq_araddr),
    .cq_arready (cq_arready),
    .cq_rvalid  (cq_rvalid),
    .cq_rdata   (cq_rdata),
    .cq_rready  (cq_rready),
    .cqdb_valid (cqdb_valid),
    .cqdb_addr  (cqdb_addr),
    .cqdb_data  (cqdb_data),
    .cqdb_ready (cqdb_ready),
    .sq_head    (sq_head),
    .cid_state  (cid_state)
  );

  write_response write_response_inst (
    .clk        (clk),
    .rstn       (rstn),
    .cid_state  (cid_state),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
  );

endmodule

// File: write_response.sv
`timescale 1ns/10ps

module write_response (
  input  logic               clk,
  input  logic               rstn,
  input  nvme_pkg::cid_vec_t cid_state,
  output logic               resp_valid,
  input  logic               resp_ready
);

  nvme_pkg::qidx_t resp_idx;
  logic            resp_phase;
  logic            resp_xfer;

  // walks the cids in issue order
  ring_index resp_ring (
    .clk   (clk),
    .rstn  (rstn),
    .step  (resp_xfer),
    .idx   (resp_idx),
    .phase (resp_phase)
  );

  // cid at the index has completed on this lap
  assign resp_valid = (cid_state[resp_idx] != resp_phase);
  assign resp_xfer  = resp_valid & resp_ready;

endmodule

// File: cq_poller.sv
`timescale 1ns/10ps

`include "nvme_params.svh"

module cq_poller (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        db_rung,
  output logic                        cq_arvalid,
  output logic [`NVME_MEM_ADDR_W-1:0] cq_araddr,
  input  logic                        cq_arready,
  input  logic                        cq_rvalid,
  input  nvme_pkg::cqe_t              cq_rdata,
  output logic                        cq_rready,
  output logic                        cqdb_valid,
  output logic [`NVME_MEM_ADDR_W-1:0] cqdb_addr,
  output logic [`NVME_DB_W-1:0]       cqdb_data,
  input  logic                        cqdb_ready,
  output nvme_pkg::qidx_t             sq_head,
  output nvme_pkg::cid_vec_t          cid_state
);

  nvme_pkg::poll_state_t state;
  nvme_pkg::poll_state_t state_nxt;
  nvme_pkg::qidx_t       cq_head;
  nvme_pkg::qidx_t       cqe_cid;
  logic                  head_phase;
  // commands rung but not yet seen in the CQ
  logic [`NVME_QIDX_W:0] pending;
  logic                  cq_rxfer;
  logic                  entry_new;
  logic                  cqe_taken;

  ring_index cq_ring (
    .clk   (clk),
    .rstn  (rstn),
    .step  (cqe_taken),
    .idx   (cq_head),
    .phase (head_phase)
  );

  assign cq_rxfer  = cq_rvalid & cq_rready;
  // controller writes the inverted phase on each new lap
  assign entry_new = (cq_rdata.phase != head_phase);
  assign cqe_taken = cq_rxfer & entry_new;
  assign cqe_cid   = cq_rdata.cid[`NVME_QIDX_W-1:0];

  assign cq_arvalid = (state == nvme_pkg::read_req);
  assign cq_rready  = (state == nvme_pkg::read_wait);
  assign cqdb_valid = (state == nvme_pkg::doorbell);

  assign cq_araddr = `NVME_MEM_ADDR_W'(cq_head) * `NVME_MEM_ADDR_W'(`NVME_CQE_BYTES);
  // head already advanced when the entry was taken
  assign cqdb_addr = `NVME_CQ1HDBL;
  assign cqdb_data = `NVME_DB_W'(cq_head);

  always_comb begin
    state_nxt = state;
    case (state)
      nvme_pkg::idle: begin
        if (pending != '0) begin
          state_nxt = nvme_pkg::read_req;
        end
      end
      nvme_pkg::read_req: begin
        if (cq_arvalid && cq_arready) begin
          state_nxt = nvme_pkg::read_wait;
        end
      end
      nvme_pkg::read_wait: begin
        // stale entry means poll the same slot again
        if (cq_rxfer) begin
          state_nxt = entry_new ? nvme_pkg::doorbell : nvme_pkg::read_req;
        end
      end
      default: begin
        if (cqdb_valid && cqdb_ready) begin
          state_nxt = nvme_pkg::idle;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= nvme_pkg::idle;
      pending   <= '0;
      sq_head   <= '0;
      cid_state <= '0;
    end else begin
      state <= state_nxt;
      if (db_rung && !cqe_taken) begin
        pending <= pending + 1'b1;
      end else if (!db_rung && cqe_taken) begin
        pending <= pending - 1'b1;
      end
      if (cqe_taken) begin
        sq_head            <= cq_rdata.sq_head[`NVME_QIDX_W-1:0];
        cid_state[cqe_cid] <= ~cid_state[cqe_cid];
      end
    end
  end

endmodule

// File: sq_doorbell.sv
`timescale 1ns/10ps

`include "nvme_params.svh"

module sq_doorbell (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        sqe_written,
  output logic                        sqdb_valid,
  output logic [`NVME_MEM_ADDR_W-1:0] sqdb_addr,
  output logic [`NVME_DB_W-1:0]       sqdb_data,
  input  logic                        sqdb_ready,
  output logic                        db_rung
);

  // written entries not yet announced to the controller
  logic [`NVME_QIDX_W:0] backlog;
  nvme_pkg::qidx_t       db_idx;
  nvme_pkg::qidx_t       db_tail;

  ring_index db_ring (
    .clk   (clk),
    .rstn  (rstn),
    .step  (db_rung),
    .idx   (db_idx),
    .phase ()
  );

  assign sqdb_valid = (backlog != '0);
  assign db_rung    = sqdb_valid & sqdb_ready;

  // new tail is one past the entry being announced
  assign db_tail   = db_idx + 1'b1;
  assign sqdb_addr = `NVME_SQ1TDBL;
  assign sqdb_data = `NVME_DB_W'(db_tail);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      backlog <= '0;
    end else if (sqe_written && !db_rung) begin
      backlog <= backlog + 1'b1;
    end else if (!sqe_written && db_rung) begin
      backlog <= backlog - 1'b1;
    end
  end

endmodule

// File: sq_submit.sv
`timescale 1ns/10ps

`include "nvme_params.svh"

module sq_submit (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         req_valid,
  input  logic [`NVME_HOST_ADDR_W-1:0] req_addr,
  output logic                         req_ready,
  input  nvme_pkg::qidx_t              sq_head,
  input  nvme_pkg::cid_vec_t           cid_state,
  output logic                         sq_wvalid,
  output logic [`NVME_MEM_ADDR_W-1:0]  sq_waddr,
  output nvme_pkg::sqe_t               sq_wdata,
  input  logic                         sq_wready,
  output logic                         sqe_written
);

  nvme_pkg::qidx_t tail;
  nvme_pkg::qidx_t tail_next;
  logic            tail_phase;
  logic            sq_not_full;
  logic            cid_free;
  logic            admit;

  // tail doubles as the cid, both advance on every accepted write
  ring_index tail_ring (
    .clk   (clk),
    .rstn  (rstn),
    .step  (sqe_written),
    .idx   (tail),
    .phase (tail_phase)
  );

  // 4-bit add wraps modulo the ring depth
  assign tail_next   = tail + 1'b1;
  assign sq_not_full = (tail_next != sq_head);
  // cid is free once its completion bit caught up with the tail lap
  assign cid_free    = (cid_state[tail] == tail_phase);
  assign admit       = sq_not_full & cid_free;

  // request and SQE write transfer on the same edge
  assign sq_wvalid   = req_valid & admit;
  assign req_ready   = sq_wvalid & sq_wready;
  assign sqe_written = sq_wvalid & sq_wready;

  assign sq_waddr = `NVME_MEM_ADDR_W'(tail) * `NVME_MEM_ADDR_W'(`NVME_SQE_BYTES);

  always_comb begin
    sq_wdata = '0;
    // prp data pointer, not fused
    sq_wdata.cdw0 = {16'(tail), 2'b00, 4'b0000, 2'b00, `NVME_OPC_WRITE};
    sq_wdata.nsid = `NVME_NSID;
    // one buffer slot per SQ entry
    sq_wdata.dptr = 128'(`NVME_WRBUF_BASE)
                  + 128'(tail) * 128'(`NVME_PAGE_BYTES);
    sq_wdata.slba = 64'(req_addr >> $clog2(`NVME_PAGE_BYTES));
  end

endmodule

// File: ring_index.sv
`timescale 1ns/10ps

`include "nvme_params.svh"

module ring_index (
  input  logic            clk,
  input  logic            rstn,
  input  logic            step,
  output nvme_pkg::qidx_t idx,
  output logic            phase
);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      idx   <= '0;
      phase <= 1'b0;
    end else if (step) begin
      // phase marks which lap of the ring we are on
      if (idx == nvme_pkg::qidx_t'(`NVME_QDEPTH - 1)) begin
        idx   <= '0;
        phase <= ~phase;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

endmodule

// File: nvme_pkg.sv
`include "nvme_params.svh"

package nvme_pkg;

  typedef logic [`NVME_QIDX_W-1:0] qidx_t;

  // one bit per cid, flipped on every completion
  typedef logic [`NVME_QDEPTH-1:0] cid_vec_t;

  // declared high dword first so cdw0 sits at bit 0
  typedef struct packed {
    logic [31:0]  cdw15;
    logic [31:0]  cdw14;
    logic [31:0]  cdw13;
    // number of blocks, 0 means one block
    logic [31:0]  cdw12;
    // cdw10 and cdw11
    logic [63:0]  slba;
    logic [127:0] dptr;
    logic [63:0]  mptr;
    logic [63:0]  cdw2_3;
    logic [31:0]  nsid;
    // cid, psdt, fuse, opcode
    logic [31:0]  cdw0;
  } sqe_t;

  typedef struct packed {
    logic [14:0] status;
    logic        phase;
    logic [15:0] cid;
    logic [15:0] sq_id;
    logic [15:0] sq_head;
    logic [31:0] dw1;
    logic [31:0] dw0;
  } cqe_t;

  typedef enum logic [1:0] {idle, read_req, read_wait, doorbell} poll_state_t;

endpackage

// File: nvme_params.svh
`ifndef NVME_PARAMS_SVH
`define NVME_PARAMS_SVH

// ring geometry
`define NVME_QDEPTH       16
`define NVME_QIDX_W       4

// bus widths
`define NVME_HOST_ADDR_W  48
`define NVME_MEM_ADDR_W   32
`define NVME_DB_W         32

// entry sizes in bits and bytes
`define NVME_SQE_W        512
`define NVME_CQE_W        128
`define NVME_SQE_BYTES    64
`define NVME_CQE_BYTES    16

// one 4 KiB buffer slot per cid, also the LBA size
`define NVME_PAGE_BYTES   4096
// write buffer region at 516 MiB
`define NVME_WRBUF_BASE   32'h2040_0000

// I/O queue 1 doorbells
`define NVME_SQ1TDBL      32'h0000_1008
`define NVME_CQ1HDBL      32'h0000_100c

`define NVME_OPC_WRITE    8'h01
`define NVME_NSID         32'd1

`endif
